//--- Makefile
# Verilator build, run and lint for the debug memory-access subsystem
TOP = mam_soc_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

//--- hw/mam_ahb3_adapter.sv
/*
 * Bus adapter between CPU port, debug engine and on-chip SRAM
 * Three-state arbiter, registered owner flag, request and response muxes
 */

module mam_ahb3_adapter
  import mam_pkg::*;
(
  input  logic            ahb3_in_clk_i,
  input  logic            reset_i,

  // CPU side, request held until hready
  input  logic            ahb3_in_hsel_i,
  input  logic            ahb3_in_hmastlock_i,
  input  logic [PLEN-1:0] ahb3_in_haddr_i,
  input  logic            ahb3_in_hwrite_i,
  input  logic [XLEN-1:0] ahb3_in_hwdata_i,
  output logic            ahb3_in_hready_o,
  output logic            ahb3_in_hresp_o,
  output logic [XLEN-1:0] ahb3_in_hrdata_o,

  // Debug engine side, Wishbone style
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  logic [PLEN-1:0] wb_adr_i,
  input  logic [XLEN-1:0] wb_dat_i,
  output logic            wb_ack_o,
  output logic            wb_err_o,
  output logic [XLEN-1:0] wb_dat_o,

  // Memory side
  output logic            mem_sel_o,
  output logic [PLEN-1:0] mem_addr_o,
  output logic            mem_write_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic            mem_ready_i,
  input  logic            mem_resp_i,
  input  logic [XLEN-1:0] mem_rdata_i
);

  logic [STATE_W-1:0] state_q;
  logic [STATE_W-1:0] state_d;
  logic               grant_cpu;
  logic               grant_mam;
  // High when the muxes point at the CPU
  logic               access_cpu_q;
  logic               cpu_sel;
  logic               mam_sel;

  // State and owner flag
  always_ff @(posedge ahb3_in_clk_i) begin
    if (reset_i) begin
      state_q      <= ARB_IDLE;
      access_cpu_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Owner follows the grant one cycle later, held while idle
      if (grant_cpu) begin
        access_cpu_q <= 1'b1;
      end else if (grant_mam) begin
        access_cpu_q <= 1'b0;
      end
    end
  end

  // Next state, debug side has priority from idle
  always_comb begin
    grant_cpu = 1'b0;
    grant_mam = 1'b0;
    state_d   = ARB_IDLE;

    case (state_q)
      ARB_IDLE: begin
        if (wb_cyc_i) begin
          state_d = ARB_MAM;
        end else if (ahb3_in_hmastlock_i) begin
          state_d = ARB_CPU;
        end
      end

      ARB_MAM: begin
        grant_mam = 1'b1;
        // Whole run stays on the debug side
        if (wb_cyc_i) begin
          state_d = ARB_MAM;
        end
      end

      ARB_CPU: begin
        grant_cpu = 1'b1;
        // Locked CPU access finishes first, then a waiting run goes next
        if (ahb3_in_hmastlock_i) begin
          state_d = ARB_CPU;
        end else if (wb_cyc_i) begin
          state_d = ARB_MAM;
        end
      end

      default: begin
        state_d = ARB_IDLE;
      end
    endcase
  end

  // Select only passes when owner flag and grant agree
  // Keeps a request out of the memory in the cycle the owner is about to flip,
  // so no response can land on the wrong side
  assign cpu_sel = access_cpu_q & grant_cpu & ahb3_in_hsel_i;
  assign mam_sel = ~access_cpu_q & ~grant_cpu & wb_stb_i;

  // Requests toward the memory
  assign mem_sel_o   = cpu_sel | mam_sel;
  assign mem_addr_o  = access_cpu_q ? ahb3_in_haddr_i : wb_adr_i;
  assign mem_write_o = access_cpu_q ? ahb3_in_hwrite_i : wb_we_i;
  assign mem_wdata_o = access_cpu_q ? ahb3_in_hwdata_i : wb_dat_i;

  // Responses to the CPU, zero when the debug side owns the bus
  assign ahb3_in_hready_o = access_cpu_q & mem_ready_i;
  assign ahb3_in_hresp_o  = access_cpu_q & mem_resp_i;
  assign ahb3_in_hrdata_o = access_cpu_q ? mem_rdata_i : '0;

  // Responses to the debug engine, zero when the CPU owns the bus
  assign wb_ack_o = ~access_cpu_q & mem_ready_i;
  assign wb_err_o = ~access_cpu_q & mem_resp_i;
  assign wb_dat_o = access_cpu_q ? '0 : mem_rdata_i;

  // After a full cycle in ARB_MAM the muxes must point at the debug engine
  a_owner_follows_mam : assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    (state_q == ARB_MAM) ##1 (state_q == ARB_MAM) |-> !access_cpu_q
  );

  // A select at the memory always belongs to a master that still holds its bus request
  a_sel_has_owner : assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    mem_sel_o |-> (access_cpu_q ? (ahb3_in_hsel_i && ahb3_in_hmastlock_i)
                                : (wb_stb_i && wb_cyc_i))
  );

endmodule

//--- hw/mam_pkg.sv
/*
 * Shared definitions for the debug memory-access subsystem
 * Bus widths, memory geometry, debug run length and arbiter states
 */

package mam_pkg;

  // Address width of every bus in the subsystem
  localparam int PLEN = 32;

  // Data width, every access is one full word
  localparam int XLEN = 32;

  // Byte address split:
  //   [PLEN-1:BYTE_AW] word address
  //   [BYTE_AW-1:0]    byte in word, ignored by the memory
  localparam int BYTE_AW = 2;
  localparam int WORD_AW = PLEN - BYTE_AW;

  // On-chip SRAM size in words
  // Highest valid byte address is (MEM_WORDS - 1) * 4 = 1020
  localparam int MEM_WORDS = 256;

  // Index bits needed to address the word array
  localparam int MEM_AW = $clog2(MEM_WORDS);

  // Debug run length field, a run is 1 to 15 words
  // A zero length command is dropped by the engine
  localparam int LEN_W = 4;

  // Arbiter state register width
  localparam int STATE_W = 2;

  // Arbiter states
  // Nobody holds the bus
  localparam logic [STATE_W-1:0] ARB_IDLE = 2'd0;
  // Debug engine owns the bus for its whole run
  localparam logic [STATE_W-1:0] ARB_MAM = 2'd1;
  // CPU owns the bus while it keeps hmastlock high
  localparam logic [STATE_W-1:0] ARB_CPU = 2'd2;

endpackage

//--- hw/mam_soc_top.sv
/*
 * Debug memory-access subsystem top level
 * Debug engine and CPU port share one SRAM through the adapter
 */

module mam_soc_top
  import mam_pkg::*;
(
  input  logic             ahb3_in_clk_i,
  input  logic             reset_i,

  // CPU port
  input  logic             ahb3_in_hsel_i,
  input  logic             ahb3_in_hmastlock_i,
  input  logic [PLEN-1:0]  ahb3_in_haddr_i,
  input  logic             ahb3_in_hwrite_i,
  input  logic [XLEN-1:0]  ahb3_in_hwdata_i,
  output logic             ahb3_in_hready_o,
  output logic             ahb3_in_hresp_o,
  output logic [XLEN-1:0]  ahb3_in_hrdata_o,

  // Debug command port
  input  logic             cmd_valid_i,
  input  logic [PLEN-1:0]  cmd_addr_i,
  input  logic             cmd_we_i,
  input  logic [LEN_W-1:0] cmd_len_i,
  input  logic [XLEN-1:0]  cmd_wdata_i,
  output logic             cmd_busy_o,
  output logic             cmd_done_o,
  output logic             cmd_err_o,
  output logic             rd_valid_o,
  output logic [XLEN-1:0]  rd_data_o
);

  // Debug engine to adapter
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  logic [PLEN-1:0] wb_adr;
  logic [XLEN-1:0] wb_dat_w;
  logic            wb_ack;
  logic            wb_err;
  logic [XLEN-1:0] wb_dat_r;

  // Adapter to memory
  logic            mem_sel;
  logic [PLEN-1:0] mem_addr;
  logic            mem_write;
  logic [XLEN-1:0] mem_wdata;
  logic            mem_ready;
  logic            mem_resp;
  logic [XLEN-1:0] mem_rdata;

  mam_wb_master mam_wb_master_i (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .reset_i       (reset_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_we_i      (cmd_we_i),
    .cmd_len_i     (cmd_len_i),
    .cmd_wdata_i   (cmd_wdata_i),
    .cmd_busy_o    (cmd_busy_o),
    .cmd_done_o    (cmd_done_o),
    .cmd_err_o     (cmd_err_o),
    .rd_valid_o    (rd_valid_o),
    .rd_data_o     (rd_data_o),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_we_o       (wb_we),
    .wb_adr_o      (wb_adr),
    .wb_dat_o      (wb_dat_w),
    .wb_ack_i      (wb_ack),
    .wb_err_i      (wb_err),
    .wb_dat_i      (wb_dat_r)
  );

  mam_ahb3_adapter mam_ahb3_adapter_i (
    .ahb3_in_clk_i       (ahb3_in_clk_i),
    .reset_i             (reset_i),
    .ahb3_in_hsel_i      (ahb3_in_hsel_i),
    .ahb3_in_hmastlock_i (ahb3_in_hmastlock_i),
    .ahb3_in_haddr_i     (ahb3_in_haddr_i),
    .ahb3_in_hwrite_i    (ahb3_in_hwrite_i),
    .ahb3_in_hwdata_i    (ahb3_in_hwdata_i),
    .ahb3_in_hready_o    (ahb3_in_hready_o),
    .ahb3_in_hresp_o     (ahb3_in_hresp_o),
    .ahb3_in_hrdata_o    (ahb3_in_hrdata_o),
    .wb_cyc_i            (wb_cyc),
    .wb_stb_i            (wb_stb),
    .wb_we_i             (wb_we),
    .wb_adr_i            (wb_adr),
    .wb_dat_i            (wb_dat_w),
    .wb_ack_o            (wb_ack),
    .wb_err_o            (wb_err),
    .wb_dat_o            (wb_dat_r),
    .mem_sel_o           (mem_sel),
    .mem_addr_o          (mem_addr),
    .mem_write_o         (mem_write),
    .mem_wdata_o         (mem_wdata),
    .mem_ready_i         (mem_ready),
    .mem_resp_i          (mem_resp),
    .mem_rdata_i         (mem_rdata)
  );

  sram_slave sram_slave_i (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .reset_i       (reset_i),
    .mem_sel_i     (mem_sel),
    .mem_addr_i    (mem_addr),
    .mem_write_i   (mem_write),
    .mem_wdata_i   (mem_wdata),
    .mem_ready_o   (mem_ready),
    .mem_resp_o    (mem_resp),
    .mem_rdata_o   (mem_rdata)
  );

endmodule

//--- hw/mam_wb_master.sv
/*
 * Debug memory-access engine
 * Turns one command pulse into a run of word accesses in one bus cycle
 */

module mam_wb_master
  import mam_pkg::*;
(
  input  logic             ahb3_in_clk_i,
  input  logic             reset_i,

  // Command port
  input  logic             cmd_valid_i,
  input  logic [PLEN-1:0]  cmd_addr_i,
  input  logic             cmd_we_i,
  input  logic [LEN_W-1:0] cmd_len_i,
  input  logic [XLEN-1:0]  cmd_wdata_i,
  output logic             cmd_busy_o,
  output logic             cmd_done_o,
  output logic             cmd_err_o,
  output logic             rd_valid_o,
  output logic [XLEN-1:0]  rd_data_o,

  // Bus master port
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output logic             wb_we_o,
  output logic [PLEN-1:0]  wb_adr_o,
  output logic [XLEN-1:0]  wb_dat_o,
  input  logic             wb_ack_i,
  input  logic             wb_err_i,
  input  logic [XLEN-1:0]  wb_dat_i
);

  // One word step in byte addresses
  localparam logic [PLEN-1:0] ADR_STEP = PLEN'(1 << BYTE_AW);

  logic             cyc_q;
  logic             stb_q;
  logic             err_q;
  logic             done_q;
  logic             rd_valid_q;
  logic             we_q;
  logic [PLEN-1:0]  adr_q;
  logic [XLEN-1:0]  dat_q;
  logic [XLEN-1:0]  rd_data_q;
  // Words still to go, including the current one
  logic [LEN_W-1:0] cnt_q;
  logic             start;
  logic             word_end;
  logic             last_word;

  // Zero length commands are dropped
  assign start     = ~cyc_q & cmd_valid_i & (cmd_len_i != '0);
  assign word_end  = stb_q & (wb_ack_i | wb_err_i);
  assign last_word = (cnt_q == LEN_W'(1));

  // Run control
  always_ff @(posedge ahb3_in_clk_i) begin
    if (reset_i) begin
      cyc_q      <= 1'b0;
      stb_q      <= 1'b0;
      err_q      <= 1'b0;
      done_q     <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      done_q     <= 1'b0;
      rd_valid_q <= 1'b0;
      if (start) begin
        cyc_q <= 1'b1;
        stb_q <= 1'b1;
        err_q <= 1'b0;
      end else if (word_end) begin
        // stb drops for one cycle between words
        stb_q      <= 1'b0;
        err_q      <= err_q | wb_err_i;
        rd_valid_q <= ~we_q;
        if (last_word) begin
          cyc_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end else if (cyc_q && !stb_q) begin
        stb_q <= 1'b1;
      end
    end
  end

  // Command latch, address and data stepping
  always_ff @(posedge ahb3_in_clk_i) begin
    if (start) begin
      adr_q <= cmd_addr_i;
      we_q  <= cmd_we_i;
      dat_q <= cmd_wdata_i;
      cnt_q <= cmd_len_i;
    end else if (word_end) begin
      adr_q <= adr_q + ADR_STEP;
      dat_q <= dat_q + XLEN'(1);
      cnt_q <= cnt_q - LEN_W'(1);
      if (!we_q) begin
        rd_data_q <= wb_dat_i;
      end
    end
  end

  assign cmd_busy_o = cyc_q;
  assign cmd_done_o = done_q;
  // Sticky over the run, valid with cmd_done_o
  assign cmd_err_o  = err_q;
  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = rd_data_q;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = stb_q;
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;

  a_stb_in_cyc : assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    wb_stb_o |-> wb_cyc_o
  );

endmodule

//--- hw/sram_slave.sv
/*
 * On-chip word SRAM
 * One wait state per access, error response past the end of memory
 */

module sram_slave
  import mam_pkg::*;
(
  input  logic            ahb3_in_clk_i,
  input  logic            reset_i,

  // Request, held by the master until ready
  input  logic            mem_sel_i,
  input  logic [PLEN-1:0] mem_addr_i,
  input  logic            mem_write_i,
  input  logic [XLEN-1:0] mem_wdata_i,

  // Response, valid for one cycle
  output logic            mem_ready_o,
  output logic            mem_resp_o,
  output logic [XLEN-1:0] mem_rdata_o
);

  logic [XLEN-1:0]    mem_q [MEM_WORDS];
  logic [WORD_AW-1:0] word_idx;
  logic [MEM_AW-1:0]  mem_idx;
  logic               in_range;
  logic               accept;
  logic               ready_q;
  logic               resp_q;
  logic [XLEN-1:0]    rdata_q;

  // Byte-in-word bits are ignored
  assign word_idx = mem_addr_i[PLEN-1:BYTE_AW];
  assign mem_idx  = word_idx[MEM_AW-1:0];
  assign in_range = (word_idx < WORD_AW'(MEM_WORDS));

  // Sel still held in the ready cycle is not a new access
  assign accept = mem_sel_i & ~ready_q;

  // Response flags and array contents
  always_ff @(posedge ahb3_in_clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      resp_q  <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      ready_q <= accept;
      // Out-of-range access answers with an error
      resp_q  <= accept & ~in_range;
      if (accept && mem_write_i && in_range) begin
        mem_q[mem_idx] <= mem_wdata_i;
      end
    end
  end

  // Read data, zero for an address past the end
  always_ff @(posedge ahb3_in_clk_i) begin
    if (accept) begin
      rdata_q <= in_range ? mem_q[mem_idx] : '0;
    end
  end

  assign mem_ready_o = ready_q;
  assign mem_resp_o  = resp_q;
  assign mem_rdata_o = rdata_q;

  // Ready is a single-cycle pulse even when sel stays high
  a_ready_pulse : assert property (
    @(posedge ahb3_in_clk_i) disable iff (reset_i)
    mem_ready_o |=> !mem_ready_o
  );

endmodule

//--- project.f
hw/mam_pkg.sv
hw/mam_ahb3_adapter.sv
hw/mam_wb_master.sv
hw/sram_slave.sv
hw/mam_soc_top.sv
testbench/mam_soc_checker.sv
testbench/mam_soc_tb.sv

//--- testbench/mam_soc_checker.sv
/*
 * Checker for the debug memory-access subsystem
 * Shadow memory, expected read data and error flags, error counting
 */

module mam_soc_checker
  import mam_pkg::*;
(
  input  logic             ahb3_in_clk_i,
  input  logic             reset_i,
  input  logic             ahb3_in_hsel_i,
  input  logic             ahb3_in_hmastlock_i,
  input  logic [PLEN-1:0]  ahb3_in_haddr_i,
  input  logic             ahb3_in_hwrite_i,
  input  logic [XLEN-1:0]  ahb3_in_hwdata_i,
  input  logic             ahb3_in_hready_i,
  input  logic             ahb3_in_hresp_i,
  input  logic [XLEN-1:0]  ahb3_in_hrdata_i,
  input  logic             cmd_valid_i,
  input  logic [PLEN-1:0]  cmd_addr_i,
  input  logic             cmd_we_i,
  input  logic [LEN_W-1:0] cmd_len_i,
  input  logic [XLEN-1:0]  cmd_wdata_i,
  input  logic             cmd_busy_i,
  input  logic             cmd_done_i,
  input  logic             cmd_err_i,
  input  logic             rd_valid_i,
  input  logic [XLEN-1:0]  rd_data_i,
  // Ordering expected for the current stimulus entry
  input  logic             mam_first_i,
  input  logic             cpu_first_i,
  output int               err_cnt_o,
  output int               chk_cnt_o
);

  logic [XLEN-1:0] shadow [MEM_WORDS];
  int              err_cnt;
  int              chk_cnt;
  // Debug run being tracked
  logic            run_active;
  logic            run_we;
  logic [PLEN-1:0] run_addr;
  logic [XLEN-1:0] run_data;
  int              run_len;
  int              rd_cnt;
  logic            cpu_wait;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  function automatic logic in_range(input logic [PLEN-1:0] addr);
    return (addr >> BYTE_AW) < PLEN'(MEM_WORDS);
  endfunction

  function automatic logic [MEM_AW-1:0] slot(input logic [PLEN-1:0] addr);
    return addr[BYTE_AW +: MEM_AW];
  endfunction

  // Byte address of word k of a run
  function automatic logic [PLEN-1:0] word_addr(input logic [PLEN-1:0] base, input int k);
    return base + PLEN'(k * (1 << BYTE_AW));
  endfunction

  // Reads past the end return zero
  function automatic logic [XLEN-1:0] expect_word(input logic [PLEN-1:0] addr);
    return in_range(addr) ? shadow[slot(addr)] : '0;
  endfunction

  task automatic compare(input string what, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic flag_problem(input string what);
    err_cnt++;
    $display("Fail at time %0t: %s", $time, what);
  endtask

  task automatic cpu_response();
    if (!ahb3_in_hsel_i) begin
      flag_problem("hready seen without a CPU request");
    end else begin
      compare("CPU hresp", XLEN'(ahb3_in_hresp_i), XLEN'(!in_range(ahb3_in_haddr_i)));
      if (ahb3_in_hwrite_i) begin
        if (!ahb3_in_hresp_i && in_range(ahb3_in_haddr_i)) begin
          shadow[slot(ahb3_in_haddr_i)] = ahb3_in_hwdata_i;
        end
      end else begin
        compare("CPU read data", ahb3_in_hrdata_i, expect_word(ahb3_in_haddr_i));
      end
      if (mam_first_i && cmd_busy_i) begin
        flag_problem("CPU access completed before the debug run ended");
      end
    end
  endtask

  task automatic debug_read_word();
    if (!run_active || run_we) begin
      flag_problem("read pulse without a debug read run");
    end else begin
      compare("debug read data", rd_data_i, expect_word(word_addr(run_addr, rd_cnt)));
      rd_cnt++;
    end
  endtask

  task automatic debug_done();
    logic            exp_err;
    int              k;
    logic [PLEN-1:0] addr;
    if (!run_active) begin
      flag_problem("cmd_done seen without a debug run");
    end else begin
      exp_err = 1'b0;
      // Out-of-range words flag an error and leave memory alone
      for (k = 0; k < run_len; k++) begin
        addr = word_addr(run_addr, k);
        if (!in_range(addr)) begin
          exp_err = 1'b1;
        end else if (run_we) begin
          shadow[slot(addr)] = run_data + XLEN'(k);
        end
      end
      compare("debug error flag", XLEN'(cmd_err_i), XLEN'(exp_err));
      compare("debug read count", XLEN'(rd_cnt), XLEN'(run_we ? 0 : run_len));
      run_active = 1'b0;
    end
  endtask

  always @(posedge ahb3_in_clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        shadow[i] = '0;
      end
      err_cnt    = 0;
      chk_cnt    = 0;
      run_active = 1'b0;
      rd_cnt     = 0;
    end else begin
      // CPU request still waiting for its response
      cpu_wait = ahb3_in_hsel_i && ahb3_in_hmastlock_i && !ahb3_in_hready_i;
      if (cpu_first_i && cpu_wait && (rd_valid_i || cmd_done_i)) begin
        flag_problem("debug run served while the CPU held the lock");
      end
      if (ahb3_in_hready_i) begin
        cpu_response();
      end
      // Last read word and done arrive together
      if (rd_valid_i) begin
        debug_read_word();
      end
      if (cmd_done_i) begin
        debug_done();
      end
      // A pulse while busy is dropped by the engine
      if (cmd_valid_i && !cmd_busy_i && cmd_len_i != '0) begin
        run_active = 1'b1;
        run_we     = cmd_we_i;
        run_addr   = cmd_addr_i;
        run_data   = cmd_wdata_i;
        run_len    = int'(cmd_len_i);
        rd_cnt     = 0;
      end
    end
  end

endmodule

//--- testbench/mam_soc_tb.sv
/*
 * Testbench for the debug memory-access subsystem
 * Clock, reset, stimulus table, driving loop and watchdog
 */

module mam_soc_tb
  import mam_pkg::*;
();

  localparam int N_STIM = 16;

  // Entry kinds
  localparam logic [2:0] K_CPU_RD    = 3'd0;
  localparam logic [2:0] K_CPU_WR    = 3'd1;
  localparam logic [2:0] K_DBG       = 3'd2;
  // Debug run and CPU lock rise together from idle
  localparam logic [2:0] K_BOTH      = 3'd3;
  // Debug command issued while the CPU holds the lock
  localparam logic [2:0] K_LOCK_DBG  = 3'd4;
  // Second pulse while the first run is busy
  localparam logic [2:0] K_DBG_TWICE = 3'd5;

  typedef struct packed {
    logic [2:0]       kind;
    logic [PLEN-1:0]  addr;
    logic [XLEN-1:0]  data;
    logic             we;
    logic [LEN_W-1:0] len;
  } stim_t;

  logic             ahb3_in_clk_i = 1'b0;
  logic             reset_i;
  logic             ahb3_in_hsel_i;
  logic             ahb3_in_hmastlock_i;
  logic [PLEN-1:0]  ahb3_in_haddr_i;
  logic             ahb3_in_hwrite_i;
  logic [XLEN-1:0]  ahb3_in_hwdata_i;
  logic             ahb3_in_hready_o;
  logic             ahb3_in_hresp_o;
  logic [XLEN-1:0]  ahb3_in_hrdata_o;
  logic             cmd_valid_i;
  logic [PLEN-1:0]  cmd_addr_i;
  logic             cmd_we_i;
  logic [LEN_W-1:0] cmd_len_i;
  logic [XLEN-1:0]  cmd_wdata_i;
  logic             cmd_busy_o;
  logic             cmd_done_o;
  logic             cmd_err_o;
  logic             rd_valid_o;
  logic [XLEN-1:0]  rd_data_o;
  logic             mam_first;
  logic             cpu_first;
  int               err_cnt;
  int               chk_cnt;
  integer           seed;
  stim_t            stim_tab [N_STIM];

  mam_soc_top mam_soc_top_i (
    .ahb3_in_clk_i       (ahb3_in_clk_i),
    .reset_i             (reset_i),
    .ahb3_in_hsel_i      (ahb3_in_hsel_i),
    .ahb3_in_hmastlock_i (ahb3_in_hmastlock_i),
    .ahb3_in_haddr_i     (ahb3_in_haddr_i),
    .ahb3_in_hwrite_i    (ahb3_in_hwrite_i),
    .ahb3_in_hwdata_i    (ahb3_in_hwdata_i),
    .ahb3_in_hready_o    (ahb3_in_hready_o),
    .ahb3_in_hresp_o     (ahb3_in_hresp_o),
    .ahb3_in_hrdata_o    (ahb3_in_hrdata_o),
    .cmd_valid_i         (cmd_valid_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_we_i            (cmd_we_i),
    .cmd_len_i           (cmd_len_i),
    .cmd_wdata_i         (cmd_wdata_i),
    .cmd_busy_o          (cmd_busy_o),
    .cmd_done_o          (cmd_done_o),
    .cmd_err_o           (cmd_err_o),
    .rd_valid_o          (rd_valid_o),
    .rd_data_o           (rd_data_o)
  );

  mam_soc_checker mam_soc_checker_i (
    .ahb3_in_clk_i       (ahb3_in_clk_i),
    .reset_i             (reset_i),
    .ahb3_in_hsel_i      (ahb3_in_hsel_i),
    .ahb3_in_hmastlock_i (ahb3_in_hmastlock_i),
    .ahb3_in_haddr_i     (ahb3_in_haddr_i),
    .ahb3_in_hwrite_i    (ahb3_in_hwrite_i),
    .ahb3_in_hwdata_i    (ahb3_in_hwdata_i),
    .ahb3_in_hready_i    (ahb3_in_hready_o),
    .ahb3_in_hresp_i     (ahb3_in_hresp_o),
    .ahb3_in_hrdata_i    (ahb3_in_hrdata_o),
    .cmd_valid_i         (cmd_valid_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_we_i            (cmd_we_i),
    .cmd_len_i           (cmd_len_i),
    .cmd_wdata_i         (cmd_wdata_i),
    .cmd_busy_i          (cmd_busy_o),
    .cmd_done_i          (cmd_done_o),
    .cmd_err_i           (cmd_err_o),
    .rd_valid_i          (rd_valid_o),
    .rd_data_i           (rd_data_o),
    .mam_first_i         (mam_first),
    .cpu_first_i         (cpu_first),
    .err_cnt_o           (err_cnt),
    .chk_cnt_o           (chk_cnt)
  );

  always #10 ahb3_in_clk_i = ~ahb3_in_clk_i;

  task automatic set_entry(input int idx, input logic [2:0] kind, input logic [PLEN-1:0] addr,
                           input logic [XLEN-1:0] data, input logic we,
                           input logic [LEN_W-1:0] len);
    stim_tab[idx].kind = kind;
    stim_tab[idx].addr = addr;
    stim_tab[idx].data = data;
    stim_tab[idx].we   = we;
    stim_tab[idx].len  = len;
  endtask

  task automatic load_table();
    // Word 0 holds a nonzero value, so a read past the end cannot return it unnoticed
    set_entry(0,  K_CPU_WR,    32'h0000_0000, $random(seed), 1'b1, 4'd1);
    set_entry(1,  K_CPU_RD,    32'h0000_0000, 32'h0,         1'b0, 4'd1);
    set_entry(2,  K_DBG,       32'h0000_0100, $random(seed), 1'b1, 4'd5);
    set_entry(3,  K_DBG,       32'h0000_0100, 32'h0,         1'b0, 4'd5);
    // 1024 and 2044 are past the last word at 1020
    set_entry(4,  K_CPU_WR,    32'h0000_0400, $random(seed), 1'b1, 4'd1);
    set_entry(5,  K_CPU_RD,    32'h0000_07fc, 32'h0,         1'b0, 4'd1);
    // Runs across the end of memory
    set_entry(6,  K_DBG,       32'h0000_03f4, $random(seed), 1'b1, 4'd4);
    set_entry(7,  K_DBG,       32'h0000_03f0, 32'h0,         1'b0, 4'd5);
    set_entry(8,  K_BOTH,      32'h0000_0200, $random(seed), 1'b1, 4'd3);
    set_entry(9,  K_LOCK_DBG,  32'h0000_0080, $random(seed), 1'b0, 4'd2);
    set_entry(10, K_CPU_RD,    32'h0000_0104, 32'h0,         1'b0, 4'd1);
    set_entry(11, K_DBG_TWICE, 32'h0000_0100, 32'h0,         1'b0, 4'd3);
    set_entry(12, K_DBG,       32'h0000_0200, 32'h0,         1'b0, 4'd3);
    set_entry(13, K_CPU_WR,    32'h0000_03fc, 32'ha5c3_0f1e, 1'b1, 4'd1);
    set_entry(14, K_CPU_RD,    32'h0000_03fc, 32'h0,         1'b0, 4'd1);
    // Word 0 still holds its first value after the writes past the end
    set_entry(15, K_CPU_RD,    32'h0000_0000, 32'h0,         1'b0, 4'd1);
  endtask

  // CPU access is always locked so the arbiter grants it
  task automatic drive_cpu(input logic [PLEN-1:0] addr, input logic we,
                           input logic [XLEN-1:0] data);
    ahb3_in_hsel_i      <= 1'b1;
    ahb3_in_hmastlock_i <= 1'b1;
    ahb3_in_haddr_i     <= addr;
    ahb3_in_hwrite_i    <= we;
    ahb3_in_hwdata_i    <= data;
  endtask

  // Hold the request until hready, then release the bus
  task automatic finish_cpu();
    do begin
      @(posedge ahb3_in_clk_i);
    end while (!ahb3_in_hready_o);
    ahb3_in_hsel_i      <= 1'b0;
    ahb3_in_hmastlock_i <= 1'b0;
    ahb3_in_hwrite_i    <= 1'b0;
  endtask

  task automatic drive_cmd(input logic [PLEN-1:0] addr, input logic we,
                           input logic [LEN_W-1:0] len, input logic [XLEN-1:0] data);
    cmd_valid_i <= 1'b1;
    cmd_addr_i  <= addr;
    cmd_we_i    <= we;
    cmd_len_i   <= len;
    cmd_wdata_i <= data;
  endtask

  task automatic wait_cmd_done();
    do begin
      @(posedge ahb3_in_clk_i);
    end while (!cmd_done_o);
  endtask

  task automatic run_entry(input stim_t s);
    case (s.kind)
      K_CPU_RD, K_CPU_WR: begin
        @(posedge ahb3_in_clk_i);
        drive_cpu(s.addr, s.we, s.data);
        finish_cpu();
      end
      K_DBG: begin
        @(posedge ahb3_in_clk_i);
        drive_cmd(s.addr, s.we, s.len, s.data);
        @(posedge ahb3_in_clk_i);
        cmd_valid_i <= 1'b0;
        wait_cmd_done();
      end
      K_BOTH: begin
        // Pulse first, so wb_cyc and hmastlock rise in the same cycle
        @(posedge ahb3_in_clk_i);
        mam_first <= 1'b1;
        drive_cmd(s.addr, s.we, s.len, s.data);
        @(posedge ahb3_in_clk_i);
        cmd_valid_i <= 1'b0;
        drive_cpu(s.addr, !s.we, ~s.data);
        fork
          finish_cpu();
          wait_cmd_done();
        join
        mam_first <= 1'b0;
      end
      K_LOCK_DBG: begin
        @(posedge ahb3_in_clk_i);
        cpu_first <= 1'b1;
        drive_cpu(s.addr, !s.we, ~s.data);
        @(posedge ahb3_in_clk_i);
        drive_cmd(s.addr, s.we, s.len, s.data);
        @(posedge ahb3_in_clk_i);
        cmd_valid_i <= 1'b0;
        fork
          finish_cpu();
          wait_cmd_done();
        join
        cpu_first <= 1'b0;
      end
      default: begin
        @(posedge ahb3_in_clk_i);
        drive_cmd(s.addr, s.we, s.len, s.data);
        @(posedge ahb3_in_clk_i);
        cmd_valid_i <= 1'b0;
        // Full length run elsewhere, must be dropped
        @(posedge ahb3_in_clk_i);
        drive_cmd(32'h0, s.we, 4'hf, s.data);
        @(posedge ahb3_in_clk_i);
        cmd_valid_i <= 1'b0;
        wait_cmd_done();
      end
    endcase
    repeat (3) @(posedge ahb3_in_clk_i);
  endtask

  task automatic print_counts();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
  endtask

  initial begin : main_flow
    int idx;
    seed                = 85474;
    reset_i             = 1'b1;
    ahb3_in_hsel_i      = 1'b0;
    ahb3_in_hmastlock_i = 1'b0;
    ahb3_in_haddr_i     = '0;
    ahb3_in_hwrite_i    = 1'b0;
    ahb3_in_hwdata_i    = '0;
    cmd_valid_i         = 1'b0;
    cmd_addr_i          = '0;
    cmd_we_i            = 1'b0;
    cmd_len_i           = '0;
    cmd_wdata_i         = '0;
    mam_first           = 1'b0;
    cpu_first           = 1'b0;
    load_table();
    repeat (2) @(posedge ahb3_in_clk_i);
    reset_i <= 1'b0;
    for (idx = 0; idx < N_STIM; idx++) begin
      run_entry(stim_tab[idx]);
    end
    repeat (4) @(posedge ahb3_in_clk_i);
    print_counts();
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Generous bound, a few dozen cycles per entry at most
  initial begin : watchdog
    repeat (N_STIM * 100) @(posedge ahb3_in_clk_i);
    $display("Timeout: no completion within %0d cycles, the run hung", N_STIM * 100);
    print_counts();
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
